/* compile.f */
rv_isa_pkg.sv
lsu_map_pkg.sv
lsu_ifs.sv
region_cfg.sv
data_bank.sv
mem_access.sv
write_back.sv
reg_file.sv
lsu_top.sv
tb_clock_gen.sv
tb_lsu.sv

/* Makefile */
SRCS := $(wildcard *.sv)

obj_dir/Vtb_lsu: compile.f $(SRCS)
	verilator --binary --timing --timescale 1ns/1ps --top-module tb_lsu -j 0 -f compile.f

run: obj_dir/Vtb_lsu
	./obj_dir/Vtb_lsu

clean:
	rm -rf obj_dir

.PHONY: run clean

/* tb_lsu.sv */
`default_nettype none

module tb_lsu;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int BANK_AW = 6;
    localparam int WORDS   = 2 ** BANK_AW;  // Words per bank
    localparam int FIELD_W = 30 - BANK_AW;
    localparam int TIMEOUT = 20;

    logic                    clk;
    logic                    rst_n;
    logic                    req_valid;
    logic                    req_is_store;
    rv_isa_pkg::funct3_t     req_funct3;
    rv_isa_pkg::addr_t       req_addr;
    rv_isa_pkg::word_t       req_store_data;
    rv_isa_pkg::word_t       req_pc_4;
    rv_isa_pkg::reg_idx_t    req_rd;
    logic                    req_reg_wr_en;
    rv_isa_pkg::wb_sel_t     req_reg_wr_ctrl;
    rv_isa_pkg::addr_t       awaddr;
    logic                    awvalid;
    logic                    awready;
    rv_isa_pkg::word_t       wdata;
    logic [3:0]              wstrb;
    logic                    wvalid;
    logic                    wready;
    lsu_map_pkg::axi_resp_t  bresp;
    logic                    bvalid;
    logic                    bready;
    rv_isa_pkg::addr_t       araddr;
    logic                    arvalid;
    logic                    arready;
    rv_isa_pkg::word_t       rdata;
    lsu_map_pkg::axi_resp_t  rresp;
    logic                    rvalid;
    logic                    rready;
    rv_isa_pkg::reg_idx_t    dbg_rd_idx;
    rv_isa_pkg::word_t       dbg_rd_data;

    // Reference model, memory indexed by physical bank and word
    rv_isa_pkg::word_t   mem_model [lsu_map_pkg::NUM_BANKS * WORDS];
    rv_isa_pkg::word_t   reg_model [32];
    logic [FIELD_W-1:0]  base_model [lsu_map_pkg::NUM_BANKS];
    int                  fault_model;
    int                  chk_idx [$];  // Register to look at, -1 for an idle slot
    rv_isa_pkg::word_t   chk_val [$];
    integer              seed;

    tb_clock_gen #(.PERIOD_NS(40)) tb_clock_gen_i (.clk);

    lsu_top #(.BANK_AW(BANK_AW)) lsu_top_i (
        .clk, .rst_n,
        .req_valid, .req_is_store, .req_funct3, .req_addr, .req_store_data,
        .req_pc_4, .req_rd, .req_reg_wr_en, .req_reg_wr_ctrl,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .dbg_rd_idx, .dbg_rd_data
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reporting

    task automatic abort_run(input string reason);
        $display("Simulation failed");
        $fatal(1, "%s", reason);
    endtask

    task automatic check_eq(input string name, input rv_isa_pkg::word_t expected,
                            input rv_isa_pkg::word_t actual);
        if (actual !== expected) begin
            $display("[FAIL] t=%0t %s expected 0x%08h actual 0x%08h",
                     $time, name, expected, actual);
            abort_run("Value mismatch");
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Model helpers

    function automatic int rand_below(input int n);
        rand_below = int'($unsigned($random(seed)) % $unsigned(n));
    endfunction

    function automatic int decode_bank(input rv_isa_pkg::addr_t addr);
        int hit;
        hit = -1;
        for (int k = 0; k < lsu_map_pkg::NUM_BANKS; k++) begin
            if (hit < 0 && base_model[k] == addr[31:BANK_AW+2]) hit = k;  // First match
        end
        return hit;
    endfunction

    function automatic logic [FIELD_W-1:0] unmapped_field();
        logic [FIELD_W-1:0] f;
        f = FIELD_W'($random(seed));
        while (decode_bank({f, {(BANK_AW + 2){1'b0}}}) >= 0) f = FIELD_W'($random(seed));
        return f;
    endfunction

    function automatic rv_isa_pkg::addr_t bank_addr(input int bank, input int word);
        return {base_model[bank], BANK_AW'(word), 2'b00};
    endfunction

    function automatic rv_isa_pkg::word_t base_word(input int bank);
        rv_isa_pkg::word_t w;
        w = '0;
        w[FIELD_W-1:0] = base_model[bank];
        return w;
    endfunction

    function automatic rv_isa_pkg::word_t fill_word(input int i);
        return (rv_isa_pkg::word_t'(i) * 32'h9E37_79B1) ^ 32'h5A5A_A5A5;
    endfunction

    function automatic rv_isa_pkg::word_t merge_store(input rv_isa_pkg::word_t old,
                                                      input rv_isa_pkg::funct3_t f3,
                                                      input logic [1:0] off,
                                                      input rv_isa_pkg::word_t st);
        rv_isa_pkg::word_t w;
        w = old;
        case (f3)
            rv_isa_pkg::SB: w[8*off +: 8] = st[7:0];
            rv_isa_pkg::SH: w[8*off +: 16] = st[15:0];
            default:        w = st;
        endcase
        return w;
    endfunction

    function automatic rv_isa_pkg::word_t extract_load(input rv_isa_pkg::word_t w,
                                                       input rv_isa_pkg::funct3_t f3,
                                                       input logic [1:0] off);
        logic [7:0]        b;
        logic [15:0]       h;
        rv_isa_pkg::word_t v;
        b = w[8*off +: 8];
        h = off[1] ? w[31:16] : w[15:0];
        case (f3)
            rv_isa_pkg::LB:  v = {{24{b[7]}}, b};
            rv_isa_pkg::LBU: v = {24'h000000, b};
            rv_isa_pkg::LH:  v = {{16{h[15]}}, h};
            rv_isa_pkg::LHU: v = {16'h0000, h};
            default:         v = w;
        endcase
        return v;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Request side, one slot per clock

    task automatic next_slot();
        @(posedge clk);
        #2;
    endtask

    // A request driven in slot s lands in the register file at the edge that opens slot s+2
    task automatic track(input int idx, input rv_isa_pkg::word_t val);
        int                old_idx;
        rv_isa_pkg::word_t old_val;
        chk_idx.push_back(idx);
        chk_val.push_back(val);
        if (chk_idx.size() > 2) begin
            old_idx = chk_idx.pop_front();
            old_val = chk_val.pop_front();
            if (old_idx >= 0) begin
                dbg_rd_idx = 5'(old_idx);
                #10;
                check_eq($sformatf("x%0d", old_idx), old_val, dbg_rd_data);
            end
        end
    endtask

    task automatic drain();
        repeat (2) begin
            next_slot();
            req_valid = 1'b0;
            track(-1, '0);
        end
        chk_idx.delete();
        chk_val.delete();
    endtask

    task automatic alu_op();
        rv_isa_pkg::reg_idx_t rd;
        rv_isa_pkg::word_t    res;
        logic                 en;
        int                   kind;
        rd   = 5'(rand_below(32));
        en   = rand_below(4) != 0;
        kind = rand_below(3);
        next_slot();
        req_valid      = 1'b1;
        req_is_store   = 1'b0;
        req_funct3     = rv_isa_pkg::LW;
        req_addr       = $random(seed);
        req_store_data = $random(seed);
        req_pc_4       = $random(seed);
        req_rd         = rd;
        req_reg_wr_en  = en;
        case (kind)
            0: begin
                req_reg_wr_ctrl = rv_isa_pkg::ALU;
                res = req_addr;
            end
            1: begin
                req_reg_wr_ctrl = rv_isa_pkg::PC4;
                res = req_pc_4;
            end
            default: begin
                req_reg_wr_ctrl = rv_isa_pkg::NONE;
                res = '0;
            end
        endcase
        if (en && rd != '0) reg_model[rd] = res;
        track(int'(rd), reg_model[rd]);
    endtask

    task automatic mem_request(input logic is_store, input rv_isa_pkg::funct3_t f3,
                               input rv_isa_pkg::addr_t addr, input rv_isa_pkg::word_t st,
                               input rv_isa_pkg::reg_idx_t rd, input logic en);
        int bank;
        int idx;
        bank = decode_bank(addr);
        idx  = bank * WORDS + int'(addr[BANK_AW+1:2]);
        next_slot();
        req_valid       = 1'b1;
        req_is_store    = is_store;
        req_funct3      = f3;
        req_addr        = addr;
        req_store_data  = st;
        req_pc_4        = $random(seed);
        req_rd          = rd;
        req_reg_wr_en   = en;
        req_reg_wr_ctrl = rv_isa_pkg::MEM;
        if (bank < 0) fault_model++;
        if (is_store) begin
            if (bank >= 0) mem_model[idx] = merge_store(mem_model[idx], f3, addr[1:0], st);
        end else if (en && rd != '0) begin
            reg_model[rd] = (bank < 0) ? '0 : extract_load(mem_model[idx], f3, addr[1:0]);
        end
        track(int'(rd), reg_model[rd]);  // Stores leave rd alone
    endtask

    task automatic pick_access(input logic is_store, output rv_isa_pkg::funct3_t f3,
                               output logic [1:0] off);
        int kind;
        off  = 2'(rand_below(4));
        kind = rand_below(is_store ? 3 : 5);
        case (kind)
            0: f3 = is_store ? rv_isa_pkg::SB : rv_isa_pkg::LB;
            1: begin
                f3 = is_store ? rv_isa_pkg::SH : rv_isa_pkg::LH;
                off[0] = 1'b0;
            end
            2: begin
                f3 = is_store ? rv_isa_pkg::SW : rv_isa_pkg::LW;
                off = 2'b00;
            end
            3: f3 = rv_isa_pkg::LBU;
            default: begin
                f3 = rv_isa_pkg::LHU;
                off[0] = 1'b0;
            end
        endcase
    endtask

    task automatic random_traffic(input int count, input int fault_pct);
        logic                 is_store;
        rv_isa_pkg::funct3_t  f3;
        logic [1:0]           off;
        logic [FIELD_W-1:0]   field;
        rv_isa_pkg::addr_t    addr;
        for (int i = 0; i < count; i++) begin
            if (rand_below(5) == 0) begin
                alu_op();
            end else begin
                is_store = rand_below(2) == 1;
                pick_access(is_store, f3, off);
                if (rand_below(100) < fault_pct) field = unmapped_field();
                else field = base_model[rand_below(lsu_map_pkg::NUM_BANKS)];
                addr = {field, BANK_AW'(rand_below(WORDS)), off};
                mem_request(is_store, f3, addr, $random(seed), 5'(rand_below(32)),
                            rand_below(8) != 0);
                if (is_store && rand_below(2) == 0) begin
                    pick_access(1'b0, f3, off);  // Same word in the very next cycle
                    addr[1:0] = off;
                    mem_request(1'b0, f3, addr, $random(seed), 5'(1 + rand_below(31)), 1'b1);
                end
            end
        end
    endtask

    task automatic fill_banks();
        for (int i = 0; i < lsu_map_pkg::NUM_BANKS * WORDS; i++) begin
            mem_request(1'b1, rv_isa_pkg::SW, bank_addr(i / WORDS, i % WORDS), fill_word(i),
                        5'(rand_below(32)), 1'b1);
        end
    endtask

    // Reads every word of every bank through the current map
    task automatic sweep_banks();
        for (int i = 0; i < lsu_map_pkg::NUM_BANKS * WORDS; i++) begin
            mem_request(1'b0, rv_isa_pkg::LW, bank_addr(i / WORDS, i % WORDS), '0,
                        5'(1 + rand_below(31)), 1'b1);
        end
        drain();
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // AXI4-Lite configuration port

    task automatic cfg_write(input rv_isa_pkg::addr_t addr, input rv_isa_pkg::word_t data,
                             input logic [3:0] strb, input lsu_map_pkg::axi_resp_t exp_resp);
        int waited;
        next_slot();
        awaddr  = addr;
        wdata   = data;
        wstrb   = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        waited  = 0;
        #10;
        while (!(awready && wready)) begin
            waited++;
            if (waited > TIMEOUT) abort_run("Write address and data were never accepted");
            next_slot();
            #10;
        end
        next_slot();  // Handshake edge has passed
        awvalid = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b1;
        waited  = 0;
        #10;
        while (!bvalid) begin
            waited++;
            if (waited > TIMEOUT) abort_run("No write response came back in 20 cycles");
            next_slot();
            #10;
        end
        check_eq("bresp", 32'(exp_resp), 32'(bresp));
        next_slot();
        bready = 1'b0;
    endtask

    task automatic cfg_read(input rv_isa_pkg::addr_t addr, input rv_isa_pkg::word_t exp_data,
                            input lsu_map_pkg::axi_resp_t exp_resp);
        int waited;
        next_slot();
        araddr  = addr;
        arvalid = 1'b1;
        waited  = 0;
        #10;
        while (!arready) begin
            waited++;
            if (waited > TIMEOUT) abort_run("Read address was never accepted");
            next_slot();
            #10;
        end
        next_slot();
        arvalid = 1'b0;
        rready  = 1'b1;
        waited  = 0;
        #10;
        while (!rvalid) begin
            waited++;
            if (waited > TIMEOUT) abort_run("No read data came back in 20 cycles");
            next_slot();
            #10;
        end
        check_eq("rresp", 32'(exp_resp), 32'(rresp));
        if (exp_resp == lsu_map_pkg::OKAY) check_eq("rdata", exp_data, rdata);
        next_slot();
        rready = 1'b0;
    endtask

    task automatic set_base(input int bank, input rv_isa_pkg::word_t data,
                            input logic [3:0] strb);
        rv_isa_pkg::word_t w;
        w = base_word(bank);
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) w[8*b +: 8] = data[8*b +: 8];
        end
        cfg_write(lsu_map_pkg::REG_BASE0 + rv_isa_pkg::addr_t'(4 * bank), data, strb,
                  lsu_map_pkg::OKAY);
        base_model[bank] = w[FIELD_W-1:0];
    endtask

    task automatic check_bases();
        for (int k = 0; k < lsu_map_pkg::NUM_BANKS; k++) begin
            cfg_read(lsu_map_pkg::REG_BASE0 + rv_isa_pkg::addr_t'(4 * k), base_word(k),
                     lsu_map_pkg::OKAY);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        seed            = 29;
        rst_n           = 1'b0;
        req_valid       = 1'b0;
        req_is_store    = 1'b0;
        req_funct3      = rv_isa_pkg::LW;
        req_addr        = '0;
        req_store_data  = '0;
        req_pc_4        = '0;
        req_rd          = '0;
        req_reg_wr_en   = 1'b0;
        req_reg_wr_ctrl = rv_isa_pkg::ALU;
        awaddr          = '0;
        awvalid         = 1'b0;
        wdata           = '0;
        wstrb           = '0;
        wvalid          = 1'b0;
        bready          = 1'b0;
        araddr          = '0;
        arvalid         = 1'b0;
        rready          = 1'b0;
        dbg_rd_idx      = '0;
        fault_model     = 0;
        for (int i = 0; i < 32; i++) reg_model[i] = '0;
        for (int i = 0; i < lsu_map_pkg::NUM_BANKS * WORDS; i++) mem_model[i] = '0;
        for (int k = 0; k < lsu_map_pkg::NUM_BANKS; k++) base_model[k] = FIELD_W'(k);

        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;

        repeat (200) alu_op();
        drain();

        fill_banks();
        random_traffic(400, 0);
        sweep_banks();

        // Swap banks 0 and 2, then move bank 3 with a single-byte strobe
        check_bases();
        set_base(0, 32'h0000_0002, 4'b1111);
        set_base(2, 32'h0000_0000, 4'b1111);
        set_base(3, 32'hFFFF_FF07, 4'b0001);
        check_bases();
        random_traffic(400, 0);
        sweep_banks();

        random_traffic(300, 15);
        sweep_banks();
        cfg_read(lsu_map_pkg::REG_FAULTS, 32'(fault_model), lsu_map_pkg::OKAY);
        cfg_write(lsu_map_pkg::REG_FAULTS, 32'h0000_0000, 4'b1111, lsu_map_pkg::SLVERR);
        cfg_write(32'h0000_0020, 32'h0000_0005, 4'b1111, lsu_map_pkg::SLVERR);
        cfg_read(32'h0000_0024, '0, lsu_map_pkg::SLVERR);
        cfg_read(lsu_map_pkg::REG_FAULTS, 32'(fault_model), lsu_map_pkg::OKAY);
        check_bases();

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS = 40
) (
    output logic clk
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule

`default_nettype wire

/* lsu_top.sv */
`default_nettype none

module lsu_top #(
    parameter int BANK_AW = 6
) (
    input  logic                    clk,
    input  logic                    rst_n,
    // Memory-stage request
    input  logic                    req_valid,
    input  logic                    req_is_store,
    input  rv_isa_pkg::funct3_t     req_funct3,
    input  rv_isa_pkg::addr_t       req_addr,
    input  rv_isa_pkg::word_t       req_store_data,
    input  rv_isa_pkg::word_t       req_pc_4,
    input  rv_isa_pkg::reg_idx_t    req_rd,
    input  logic                    req_reg_wr_en,
    input  rv_isa_pkg::wb_sel_t     req_reg_wr_ctrl,
    // AXI4-Lite configuration port
    input  rv_isa_pkg::addr_t       awaddr,
    input  logic                    awvalid,
    output logic                    awready,
    input  rv_isa_pkg::word_t       wdata,
    input  logic [3:0]              wstrb,
    input  logic                    wvalid,
    output logic                    wready,
    output lsu_map_pkg::axi_resp_t  bresp,
    output logic                    bvalid,
    input  logic                    bready,
    input  rv_isa_pkg::addr_t       araddr,
    input  logic                    arvalid,
    output logic                    arready,
    output rv_isa_pkg::word_t       rdata,
    output lsu_map_pkg::axi_resp_t  rresp,
    output logic                    rvalid,
    input  logic                    rready,
    // Register file observation
    input  rv_isa_pkg::reg_idx_t    dbg_rd_idx,
    output rv_isa_pkg::word_t       dbg_rd_data
);
    logic [29-BANK_AW:0]   bank_base [lsu_map_pkg::NUM_BANKS];
    logic                  fault;
    rv_isa_pkg::word_t     rf_wr_data;
    rv_isa_pkg::reg_idx_t  rf_wr_idx;
    logic                  rf_wr_en;

    memwb_if                      wb_bus ();
    bank_if #(.BANK_AW(BANK_AW))  bank_bus [lsu_map_pkg::NUM_BANKS] ();

    region_cfg #(.BANK_AW(BANK_AW)) region_cfg_i (
        .clk, .rst_n,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .bank_base, .fault
    );

    mem_access #(.BANK_AW(BANK_AW)) mem_access_i (
        .clk, .rst_n,
        .req_valid, .req_is_store, .req_funct3, .req_addr, .req_store_data,
        .req_pc_4, .req_rd, .req_reg_wr_en, .req_reg_wr_ctrl,
        .bank_base, .fault,
        .banks (bank_bus),
        .wb    (wb_bus)
    );

    for (genvar k = 0; k < lsu_map_pkg::NUM_BANKS; k++) begin : g_bank
        data_bank #(.BANK_AW(BANK_AW)) data_bank_i (
            .clk,
            .bus (bank_bus[k])
        );
    end

    write_back write_back_i (
        .wb          (wb_bus),
        .banks       (bank_bus),
        .reg_wr_data (rf_wr_data),
        .rd          (rf_wr_idx),
        .reg_wr_en   (rf_wr_en)
    );

    reg_file reg_file_i (
        .clk, .rst_n,
        .wr_en   (rf_wr_en),
        .wr_idx  (rf_wr_idx),
        .wr_data (rf_wr_data),
        .rd_idx  (dbg_rd_idx),
        .rd_data (dbg_rd_data)
    );

endmodule

`default_nettype wire

/* reg_file.sv */
`default_nettype none

module reg_file (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  wr_en,
    input  rv_isa_pkg::reg_idx_t  wr_idx,
    input  rv_isa_pkg::word_t     wr_data,
    input  rv_isa_pkg::reg_idx_t  rd_idx,
    output rv_isa_pkg::word_t     rd_data
);
    rv_isa_pkg::word_t regs [32];

    // x0 is never written, so it stays at its reset value
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_idx != '0) begin
            regs[wr_idx] <= wr_data;
        end
    end

    assign rd_data = regs[rd_idx];

endmodule

`default_nettype wire

/* write_back.sv */
`default_nettype none

module write_back (
    memwb_if.consumer               wb,
    bank_if.reader                  banks [lsu_map_pkg::NUM_BANKS],
    output rv_isa_pkg::word_t       reg_wr_data,
    output rv_isa_pkg::reg_idx_t    rd,
    output logic                    reg_wr_en
);
    rv_isa_pkg::word_t  bank_rdata [lsu_map_pkg::NUM_BANKS];
    rv_isa_pkg::word_t  mem_word;
    rv_isa_pkg::word_t  shifted;
    rv_isa_pkg::word_t  load_val;

    assign rd        = wb.rd;
    assign reg_wr_en = wb.reg_wr_en;

    for (genvar k = 0; k < lsu_map_pkg::NUM_BANKS; k++) begin : g_rdata
        assign bank_rdata[k] = banks[k].rdata;
    end

    assign mem_word = bank_rdata[wb.mem_sel];
    assign shifted  = mem_word >> {wb.byte_offset, 3'b000};  // Addressed byte to lane 0

    always_comb begin
        case (wb.funct3)
            rv_isa_pkg::LW:  load_val = mem_word;
            rv_isa_pkg::LH:  load_val = {{16{shifted[15]}}, shifted[15:0]};
            rv_isa_pkg::LB:  load_val = {{24{shifted[7]}}, shifted[7:0]};
            rv_isa_pkg::LHU: load_val = {16'h0000, shifted[15:0]};
            rv_isa_pkg::LBU: load_val = {24'h000000, shifted[7:0]};
            default:         load_val = '0;
        endcase
    end

    always_comb begin
        case (wb.reg_wr_ctrl)
            rv_isa_pkg::ALU: reg_wr_data = wb.alu_out;
            rv_isa_pkg::PC4: reg_wr_data = wb.pc_4;
            rv_isa_pkg::MEM: reg_wr_data = wb.fault ? '0 : load_val;  // Unmapped load reads zero
            default:         reg_wr_data = '0;
        endcase
    end

endmodule

`default_nettype wire

/* mem_access.sv */
`default_nettype none

module mem_access #(
    parameter int BANK_AW = 6,
    localparam int FIELD_W = 30 - BANK_AW
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   req_valid,
    input  logic                   req_is_store,
    input  rv_isa_pkg::funct3_t    req_funct3,
    input  rv_isa_pkg::addr_t      req_addr,
    input  rv_isa_pkg::word_t      req_store_data,
    input  rv_isa_pkg::word_t      req_pc_4,
    input  rv_isa_pkg::reg_idx_t   req_rd,
    input  logic                   req_reg_wr_en,
    input  rv_isa_pkg::wb_sel_t    req_reg_wr_ctrl,
    input  logic [FIELD_W-1:0]     bank_base [lsu_map_pkg::NUM_BANKS],
    output logic                   fault,
    bank_if.master                 banks [lsu_map_pkg::NUM_BANKS],
    memwb_if.producer              wb
);
    logic                    mem_op;
    logic                    hit;
    lsu_map_pkg::bank_sel_t  sel;
    rv_isa_pkg::byte_off_t   offset;
    logic [3:0]              be;
    rv_isa_pkg::word_t       lane_data;

    assign mem_op = req_valid && (req_is_store || req_reg_wr_ctrl == rv_isa_pkg::MEM);
    assign offset = req_addr[1:0];
    assign fault  = mem_op && !hit;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bank decode, lowest matching bank wins
    always_comb begin
        hit = 1'b0;
        sel = '0;
        for (int k = lsu_map_pkg::NUM_BANKS - 1; k >= 0; k--) begin
            if (bank_base[k] == req_addr[31:BANK_AW+2]) begin
                hit = 1'b1;
                sel = lsu_map_pkg::bank_sel_t'(k);
            end
        end
    end

    // Store data is replicated so every lane carries the right bytes
    always_comb begin
        be        = 4'b0000;
        lane_data = req_store_data;
        case (req_funct3)
            rv_isa_pkg::SB: begin
                be        = 4'b0001 << offset;
                lane_data = {4{req_store_data[7:0]}};
            end
            rv_isa_pkg::SH: begin
                be        = 4'b0011 << offset;
                lane_data = {2{req_store_data[15:0]}};
            end
            rv_isa_pkg::SW: be = 4'b1111;
            default: ;
        endcase
    end

    for (genvar k = 0; k < lsu_map_pkg::NUM_BANKS; k++) begin : g_bank
        assign banks[k].en    = mem_op && hit && (sel == lsu_map_pkg::bank_sel_t'(k));
        assign banks[k].we    = req_is_store;
        assign banks[k].addr  = req_addr[BANK_AW+1:2];
        assign banks[k].be    = be;
        assign banks[k].wdata = lane_data;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // MEM/WB register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb.reg_wr_en <= 1'b0;
            wb.fault     <= 1'b0;
        end else begin
            wb.reg_wr_en <= req_valid && !req_is_store && req_reg_wr_en;
            wb.fault     <= fault;
        end
    end

    always_ff @(posedge clk) begin
        wb.alu_out     <= req_addr;  // The ALU result of a memory op is its address
        wb.pc_4        <= req_pc_4;
        wb.funct3      <= req_funct3;
        wb.byte_offset <= offset;
        wb.rd          <= req_rd;
        wb.reg_wr_ctrl <= req_reg_wr_ctrl;
        wb.mem_sel     <= sel;
    end

endmodule

`default_nettype wire

/* data_bank.sv */
`default_nettype none

module data_bank #(
    parameter int BANK_AW = 6
) (
    input  logic    clk,
    bank_if.slave   bus
);
    localparam int DEPTH = 2 ** BANK_AW;

    rv_isa_pkg::word_t mem [DEPTH];

    // Single port, so a cycle either writes or reads
    always_ff @(posedge clk) begin
        if (bus.en) begin
            if (bus.we) begin
                for (int b = 0; b < 4; b++) begin
                    if (bus.be[b]) mem[bus.addr][8*b +: 8] <= bus.wdata[8*b +: 8];
                end
            end else begin
                bus.rdata <= mem[bus.addr];  // Held until the next read
            end
        end
    end

endmodule

`default_nettype wire

/* region_cfg.sv */
`default_nettype none

module region_cfg #(
    parameter int BANK_AW = 6,
    localparam int FIELD_W = 30 - BANK_AW
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  rv_isa_pkg::addr_t       awaddr,
    input  logic                    awvalid,
    output logic                    awready,
    input  rv_isa_pkg::word_t       wdata,
    input  logic [3:0]              wstrb,
    input  logic                    wvalid,
    output logic                    wready,
    output lsu_map_pkg::axi_resp_t  bresp,
    output logic                    bvalid,
    input  logic                    bready,
    input  rv_isa_pkg::addr_t       araddr,
    input  logic                    arvalid,
    output logic                    arready,
    output rv_isa_pkg::word_t       rdata,
    output lsu_map_pkg::axi_resp_t  rresp,
    output logic                    rvalid,
    input  logic                    rready,
    output logic [FIELD_W-1:0]      bank_base [lsu_map_pkg::NUM_BANKS],
    input  logic                    fault
);
    typedef enum logic {W_IDLE, W_RESP} wr_state_t;
    typedef enum logic {R_IDLE, R_RESP} rd_state_t;

    wr_state_t          w_state;
    rd_state_t          r_state;
    logic               aw_fire;
    logic               ar_fire;
    rv_isa_pkg::word_t  wr_merged;
    rv_isa_pkg::word_t  fault_cnt;

    assign awready = (w_state == W_IDLE) && awvalid && wvalid;  // Address and data together
    assign wready  = awready;
    assign aw_fire = awready;
    assign bvalid  = (w_state == W_RESP);

    assign arready = (r_state == R_IDLE) && arvalid;
    assign ar_fire = arready;
    assign rvalid  = (r_state == R_RESP);

    // Byte lanes of the addressed base register, with wstrb applied
    always_comb begin
        wr_merged = rv_isa_pkg::word_t'(bank_base[awaddr[3:2]]);
        for (int b = 0; b < 4; b++) begin
            if (wstrb[b]) wr_merged[8*b +: 8] = wdata[8*b +: 8];
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Write channel
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            w_state <= W_IDLE;
            for (int k = 0; k < lsu_map_pkg::NUM_BANKS; k++) begin
                bank_base[k] <= FIELD_W'(k);  // Contiguous banks from address 0
            end
        end else begin
            case (w_state)
                W_IDLE: if (aw_fire) begin
                    w_state <= W_RESP;
                    case (awaddr)
                        lsu_map_pkg::REG_BASE0, lsu_map_pkg::REG_BASE1,
                        lsu_map_pkg::REG_BASE2, lsu_map_pkg::REG_BASE3:
                            bank_base[awaddr[3:2]] <= wr_merged[FIELD_W-1:0];
                        default: ;
                    endcase
                end
                W_RESP: if (bready) w_state <= W_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (aw_fire) begin
            case (awaddr)
                lsu_map_pkg::REG_BASE0, lsu_map_pkg::REG_BASE1,
                lsu_map_pkg::REG_BASE2, lsu_map_pkg::REG_BASE3: bresp <= lsu_map_pkg::OKAY;
                default: bresp <= lsu_map_pkg::SLVERR;  // Fault counter is read only
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read channel
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            r_state <= R_IDLE;
        end else begin
            case (r_state)
                R_IDLE: if (ar_fire) r_state <= R_RESP;
                R_RESP: if (rready) r_state <= R_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (ar_fire) begin
            rresp <= lsu_map_pkg::OKAY;
            case (araddr)
                lsu_map_pkg::REG_BASE0, lsu_map_pkg::REG_BASE1,
                lsu_map_pkg::REG_BASE2, lsu_map_pkg::REG_BASE3:
                    rdata <= rv_isa_pkg::word_t'(bank_base[araddr[3:2]]);
                lsu_map_pkg::REG_FAULTS: rdata <= fault_cnt;
                default: begin
                    rdata <= '0;
                    rresp <= lsu_map_pkg::SLVERR;
                end
            endcase
        end
    end

    // Saturating count of unmapped accesses
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fault_cnt <= '0;
        end else if (fault && fault_cnt != '1) begin
            fault_cnt <= fault_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* lsu_ifs.sv */
`default_nettype none

// MEM/WB pipeline register contents
interface memwb_if;
    rv_isa_pkg::word_t       alu_out;
    rv_isa_pkg::word_t       pc_4;
    rv_isa_pkg::funct3_t     funct3;
    rv_isa_pkg::byte_off_t   byte_offset;
    rv_isa_pkg::reg_idx_t    rd;
    logic                    reg_wr_en;
    rv_isa_pkg::wb_sel_t     reg_wr_ctrl;
    lsu_map_pkg::bank_sel_t  mem_sel;
    logic                    fault;

    modport producer (output alu_out, pc_4, funct3, byte_offset, rd, reg_wr_en,
                      reg_wr_ctrl, mem_sel, fault);
    modport consumer (input alu_out, pc_4, funct3, byte_offset, rd, reg_wr_en,
                      reg_wr_ctrl, mem_sel, fault);
endinterface

// One data bank port, word addressed
interface bank_if #(parameter int BANK_AW = 6);
    logic               en;
    logic               we;
    logic [BANK_AW-1:0] addr;
    logic [3:0]         be;
    rv_isa_pkg::word_t  wdata;
    rv_isa_pkg::word_t  rdata;

    modport master (output en, we, addr, be, wdata, input rdata);
    modport slave  (input en, we, addr, be, wdata, output rdata);
    modport reader (input rdata);
endinterface

`default_nettype wire

/* lsu_map_pkg.sv */
`default_nettype none

package lsu_map_pkg;

    localparam int NUM_BANKS = 4;

    typedef logic [1:0] bank_sel_t;

    // Configuration register map, byte offsets
    localparam rv_isa_pkg::addr_t REG_BASE0  = 32'h0000_0000;
    localparam rv_isa_pkg::addr_t REG_BASE1  = 32'h0000_0004;
    localparam rv_isa_pkg::addr_t REG_BASE2  = 32'h0000_0008;
    localparam rv_isa_pkg::addr_t REG_BASE3  = 32'h0000_000C;
    localparam rv_isa_pkg::addr_t REG_FAULTS = 32'h0000_0010;  // Read only

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_t;

endpackage

`default_nettype wire

/* rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [1:0]  byte_off_t;

    // Load and store share the low funct3 encodings
    typedef enum logic [2:0] {
        LB  = 3'b000,
        LH  = 3'b001,
        LW  = 3'b010,
        LBU = 3'b100,
        LHU = 3'b101
    } funct3_t;

    localparam funct3_t SB = LB;
    localparam funct3_t SH = LH;
    localparam funct3_t SW = LW;

    // Source of the register write data
    typedef enum logic [1:0] {
        ALU  = 2'd0,
        PC4  = 2'd1,
        MEM  = 2'd2,
        NONE = 2'd3  // Writes zero
    } wb_sel_t;

endpackage

`default_nettype wire
